// File: design/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // ****************************************
    // Bus geometry
    // ****************************************
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 32;
    localparam int BE_W     = DATA_W / 8;          // Byte lanes per word
    localparam int BYTE_OFF = $clog2(BE_W);        // Byte offset bits in an address

    // On-chip memories
    localparam int RAM_DEPTH = 256;
    localparam int RAM_AW    = $clog2(RAM_DEPTH);
    localparam int ROM_DEPTH = 16;
    localparam int ROM_AW    = $clog2(ROM_DEPTH);

    // ****************************************
    // Address map
    // ****************************************
    localparam logic [ADDR_W-1:0] RAM_BASE = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] RAM_MASK = ~ADDR_W'(RAM_DEPTH * BE_W - 1);

    localparam logic [ADDR_W-1:0] ROM_BASE = 32'h1FC0_0000;
    localparam logic [ADDR_W-1:0] ROM_MASK = ~ADDR_W'(ROM_DEPTH * BE_W - 1);

    localparam logic [ADDR_W-1:0] UART_DATA_ADDR = 32'hBFD0_03F8;
    localparam logic [ADDR_W-1:0] UART_STAT_ADDR = 32'hBFD0_03FC;

    // UART transmitter timing
    localparam int BAUD_DIV   = 8;                 // Clocks per serial bit
    localparam int FRAME_BITS = 10;                // Start, 8 data, stop
    localparam int BAUD_CW    = $clog2(BAUD_DIV);
    localparam int BIT_CW     = $clog2(FRAME_BITS);

    // Which target an access lands on
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_ROM,
        TGT_UART
    } tgt_e;

endpackage

`default_nettype wire

// File: design/dbus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dbus_decode (
    input  wire  [soc_pkg::ADDR_W-1:0] master_address_i,
    input  wire  [soc_pkg::BE_W-1:0]   master_byteenable_i,
    input  wire                        master_read_i,
    input  wire                        master_write_i,
    input  wire  [soc_pkg::DATA_W-1:0] master_wrdata_i,
    output logic                       ram_rd_o,
    output logic                       ram_wr_o,
    output logic [soc_pkg::RAM_AW-1:0] ram_addr_o,
    output logic [soc_pkg::BE_W-1:0]   ram_be_o,
    output logic [soc_pkg::DATA_W-1:0] wrdata_o,
    output logic                       rom_rd_o,
    output logic [soc_pkg::ROM_AW-1:0] rom_addr_o,
    output logic                       uart_rd_o,
    output logic                       uart_wr_o,
    output logic                       uart_sel_stat_o,
    output soc_pkg::tgt_e              tgt_o
);

    import soc_pkg::*;

    logic ram_hit;
    logic rom_hit;
    logic uart_data_hit;
    logic uart_stat_hit;

    // Region match on the upper address bits
    assign ram_hit       = (master_address_i & RAM_MASK) == RAM_BASE;
    assign rom_hit       = (master_address_i & ROM_MASK) == ROM_BASE;
    assign uart_data_hit = master_address_i == UART_DATA_ADDR;
    assign uart_stat_hit = master_address_i == UART_STAT_ADDR;

    always_comb begin
        tgt_o = TGT_NONE;
        if (ram_hit) begin
            tgt_o = TGT_RAM;
        end else if (rom_hit) begin
            tgt_o = TGT_ROM;
        end else if (uart_data_hit || uart_stat_hit) begin
            tgt_o = TGT_UART;
        end
    end

    // ****************************************
    // Qualified per-target strobes
    // ****************************************
    assign ram_rd_o  = (tgt_o == TGT_RAM) && master_read_i;
    assign ram_wr_o  = (tgt_o == TGT_RAM) && master_write_i;
    assign rom_rd_o  = (tgt_o == TGT_ROM) && master_read_i;     // ROM ignores writes
    assign uart_rd_o = (tgt_o == TGT_UART) && master_read_i;
    assign uart_wr_o = uart_data_hit && master_write_i;         // Status is read-only

    assign uart_sel_stat_o = uart_stat_hit;

    // Word index inside each region
    assign ram_addr_o = master_address_i[BYTE_OFF +: RAM_AW];
    assign rom_addr_o = master_address_i[BYTE_OFF +: ROM_AW];
    assign ram_be_o   = master_byteenable_i;
    assign wrdata_o   = master_wrdata_i;

endmodule

`default_nettype wire

// File: design/bus_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bus_ram (
    input  wire                        clk_i,
    input  wire                        ram_rd_i,
    input  wire                        ram_wr_i,
    input  wire  [soc_pkg::RAM_AW-1:0] ram_addr_i,
    input  wire  [soc_pkg::BE_W-1:0]   ram_be_i,
    input  wire  [soc_pkg::DATA_W-1:0] wrdata_i,
    output logic [soc_pkg::DATA_W-1:0] rdata_o
);

    import soc_pkg::*;

    logic [DATA_W-1:0] mem [RAM_DEPTH];

    // ****************************************
    // Byte-lane writes
    // ****************************************
    always_ff @(posedge clk_i) begin
        if (ram_wr_i) begin
            for (int b = 0; b < BE_W; b++) begin
                if (ram_be_i[b]) begin
                    mem[ram_addr_i][b*8 +: 8] <= wrdata_i[b*8 +: 8];
                end
            end
        end
    end

    // Full word registered on a read
    always_ff @(posedge clk_i) begin
        if (ram_rd_i) begin
            rdata_o <= mem[ram_addr_i];
        end
    end

endmodule

`default_nettype wire

// File: design/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
    input  wire                        clk_i,
    input  wire                        rom_rd_i,
    input  wire  [soc_pkg::ROM_AW-1:0] rom_addr_i,
    output logic [soc_pkg::DATA_W-1:0] rdata_o
);

    import soc_pkg::*;

    logic [DATA_W-1:0] mem [ROM_DEPTH];

    // Boot image from the project root
    initial begin
        $readmemh("design/boot_rom.hex", mem);
    end

    always_ff @(posedge clk_i) begin
        if (rom_rd_i) begin
            rdata_o <= mem[rom_addr_i];
        end
    end

endmodule

`default_nettype wire

// File: design/uart_tx_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_regs (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        uart_rd_i,
    input  wire                        uart_wr_i,
    input  wire                        uart_sel_stat_i,
    input  wire  [soc_pkg::DATA_W-1:0] wrdata_i,
    output logic [soc_pkg::DATA_W-1:0] rdata_o,
    output logic                       txd_o
);

    import soc_pkg::*;

    logic                  busy_q;
    logic [BAUD_CW-1:0]    baud_cnt_q;
    logic [BIT_CW-1:0]     bit_cnt_q;
    logic [7:0]            shift_q;       // Data bits LSB first
    logic [7:0]            last_byte_q;
    logic                  accept;

    // Writes while a frame is running are dropped
    assign accept = uart_wr_i && !busy_q;

    // ****************************************
    // 8N1 serialiser
    // ****************************************
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            baud_cnt_q  <= '0;
            bit_cnt_q   <= '0;
            txd_o       <= 1'b1;          // Line idles high
            last_byte_q <= '0;
        end else if (accept) begin
            busy_q      <= 1'b1;
            baud_cnt_q  <= '0;
            bit_cnt_q   <= '0;
            txd_o       <= 1'b0;          // Start bit
            last_byte_q <= wrdata_i[7:0];
        end else if (busy_q) begin
            if (baud_cnt_q == BAUD_CW'(BAUD_DIV - 1)) begin
                baud_cnt_q <= '0;
                if (bit_cnt_q == BIT_CW'(FRAME_BITS - 1)) begin
                    busy_q <= 1'b0;       // Stop bit done
                    txd_o  <= 1'b1;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    txd_o     <= shift_q[0];
                end
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end
        end
    end

    // Shift register holds payload only
    always_ff @(posedge clk_i) begin
        if (accept) begin
            shift_q <= wrdata_i[7:0];
        end else if (busy_q && baud_cnt_q == BAUD_CW'(BAUD_DIV - 1)) begin
            shift_q <= {1'b1, shift_q[7:1]};
        end
    end

    // ****************************************
    // Register read port
    // ****************************************
    always_ff @(posedge clk_i) begin
        if (uart_rd_i) begin
            if (uart_sel_stat_i) begin
                rdata_o <= {{(DATA_W-1){1'b0}}, !busy_q};     // Bit 0 is ready
            end else begin
                rdata_o <= {{(DATA_W-8){1'b0}}, last_byte_q};
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dbus_result.sv
`timescale 1ns/1ps
`default_nettype none

module dbus_result (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire  soc_pkg::tgt_e        tgt_i,
    input  wire                        master_read_i,
    input  wire  [soc_pkg::DATA_W-1:0] ram_rdata_i,
    input  wire  [soc_pkg::DATA_W-1:0] rom_rdata_i,
    input  wire  [soc_pkg::DATA_W-1:0] uart_rdata_i,
    output logic [soc_pkg::DATA_W-1:0] master_rddata_o
);

    import soc_pkg::*;

    tgt_e rd_tgt_q;

    // Target of the read issued last cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_tgt_q <= TGT_NONE;
        end else if (master_read_i) begin
            rd_tgt_q <= tgt_i;
        end else begin
            rd_tgt_q <= TGT_NONE;         // No read returns zero
        end
    end

    always_comb begin
        case (rd_tgt_q)
            TGT_RAM:  master_rddata_o = ram_rdata_i;
            TGT_ROM:  master_rddata_o = rom_rdata_i;
            TGT_UART: master_rddata_o = uart_rdata_i;
            default:  master_rddata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire  [soc_pkg::ADDR_W-1:0] master_address_i,
    input  wire  [soc_pkg::BE_W-1:0]   master_byteenable_i,
    input  wire                        master_read_i,
    input  wire                        master_write_i,
    input  wire  [soc_pkg::DATA_W-1:0] master_wrdata_i,
    output logic [soc_pkg::DATA_W-1:0] master_rddata_o,
    output logic                       txd_o
);

    import soc_pkg::*;

    // ****************************************
    // Decode to target wires
    // ****************************************
    logic              ram_rd;
    logic              ram_wr;
    logic [RAM_AW-1:0] ram_addr;
    logic [BE_W-1:0]   ram_be;
    logic [DATA_W-1:0] wrdata;
    logic              rom_rd;
    logic [ROM_AW-1:0] rom_addr;
    logic              uart_rd;
    logic              uart_wr;
    logic              uart_sel_stat;
    tgt_e              tgt;

    // Target read data
    logic [DATA_W-1:0] ram_rdata;
    logic [DATA_W-1:0] rom_rdata;
    logic [DATA_W-1:0] uart_rdata;

    dbus_decode i_dbus_decode (
        .master_address_i    (master_address_i),
        .master_byteenable_i (master_byteenable_i),
        .master_read_i       (master_read_i),
        .master_write_i      (master_write_i),
        .master_wrdata_i     (master_wrdata_i),
        .ram_rd_o            (ram_rd),
        .ram_wr_o            (ram_wr),
        .ram_addr_o          (ram_addr),
        .ram_be_o            (ram_be),
        .wrdata_o            (wrdata),
        .rom_rd_o            (rom_rd),
        .rom_addr_o          (rom_addr),
        .uart_rd_o           (uart_rd),
        .uart_wr_o           (uart_wr),
        .uart_sel_stat_o     (uart_sel_stat),
        .tgt_o               (tgt)
    );

    bus_ram i_bus_ram (
        .clk_i      (clk_i),
        .ram_rd_i   (ram_rd),
        .ram_wr_i   (ram_wr),
        .ram_addr_i (ram_addr),
        .ram_be_i   (ram_be),
        .wrdata_i   (wrdata),
        .rdata_o    (ram_rdata)
    );

    boot_rom i_boot_rom (
        .clk_i      (clk_i),
        .rom_rd_i   (rom_rd),
        .rom_addr_i (rom_addr),
        .rdata_o    (rom_rdata)
    );

    uart_tx_regs i_uart_tx_regs (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .uart_rd_i       (uart_rd),
        .uart_wr_i       (uart_wr),
        .uart_sel_stat_i (uart_sel_stat),
        .wrdata_i        (wrdata),
        .rdata_o         (uart_rdata),
        .txd_o           (txd_o)
    );

    // Read data back to the master one cycle later
    dbus_result i_dbus_result (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .tgt_i           (tgt),
        .master_read_i   (master_read_i),
        .ram_rdata_i     (ram_rdata),
        .rom_rdata_i     (rom_rdata),
        .uart_rdata_i    (uart_rdata),
        .master_rddata_o (master_rddata_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus_top;

    import soc_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int STIM_DELAY = 10;
    localparam int N_RAM_MIX  = 128;
    localparam int N_UART     = 4;
    localparam int N_RANDOM   = 800;
    localparam int FRAME_CYC  = FRAME_BITS * BAUD_DIV;
    localparam int N_ACCESS   = 64 + 3 * RAM_DEPTH + N_RANDOM;
    localparam int TIMEOUT_CYCLES = (N_ACCESS + (N_UART + 1) * FRAME_CYC) * 2;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] master_address;
    logic [BE_W-1:0]   master_byteenable;
    logic              master_read;
    logic              master_write;
    logic [DATA_W-1:0] master_wrdata;
    logic [DATA_W-1:0] master_rddata;
    logic              txd;

    // Reference model state
    logic [DATA_W-1:0] model_ram [RAM_DEPTH];
    logic [DATA_W-1:0] rom_image [ROM_DEPTH];
    logic [DATA_W-1:0] exp_rd;          // Due on master_rddata next cycle
    logic [7:0]        last_byte;
    logic [7:0]        exp_bytes [$];
    int                busy_cnt;
    int                cycle_cnt;
    logic [31:0]       rng_state;

    soc_bus_top i_soc_bus_top (
        .clk_i               (clk),
        .rst_n_i             (rst_n),
        .master_address_i    (master_address),
        .master_byteenable_i (master_byteenable),
        .master_read_i       (master_read),
        .master_write_i      (master_write),
        .master_wrdata_i     (master_wrdata),
        .master_rddata_o     (master_rddata),
        .txd_o               (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ****************************************
    // Error reporting and compare tasks
    // ****************************************
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            report_error($sformatf("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                                   $time, name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            report_error($sformatf("FAILED at %0t ns: %s expected 0x%02h, got 0x%02h",
                                   $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_error($sformatf("FAILED at %0t ns: %s expected %b, got %b",
                                   $time, name, exp, act));
        end
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Byte address for a target with sel picking the word, register or unmapped spot
    function automatic logic [ADDR_W-1:0] make_addr(input tgt_e kind, input logic [31:0] sel);
        case (kind)
            TGT_RAM:  return RAM_BASE + (ADDR_W'(sel[RAM_AW-1:0]) << BYTE_OFF);
            TGT_ROM:  return ROM_BASE + (ADDR_W'(sel[ROM_AW-1:0]) << BYTE_OFF);
            TGT_UART: return sel[0] ? UART_STAT_ADDR : UART_DATA_ADDR;
            default: begin
                case (sel[1:0])
                    2'd0:    return {4'h4, sel[27:2], 2'b00};
                    2'd1:    return RAM_BASE + 32'h400 + (ADDR_W'(sel[9:2]) << 2);
                    2'd2:    return ROM_BASE + 32'h40 + (ADDR_W'(sel[5:2]) << 2);
                    default: return sel[2] ? UART_DATA_ADDR - 4 : UART_STAT_ADDR + 4;
                endcase
            end
        endcase
    endfunction

    // One bus cycle that checks the last read, drives this access and advances the model
    task automatic bus_access(input tgt_e kind, input logic [31:0] sel, input logic rd,
                              input logic wr, input logic [BE_W-1:0] be,
                              input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] next_exp;
        logic [RAM_AW-1:0] ram_idx;
        check_word("master_rddata_o", exp_rd, master_rddata);
        master_address    = make_addr(kind, sel);
        master_byteenable = be;
        master_read       = rd;
        master_write      = wr;
        master_wrdata     = data;
        ram_idx  = sel[RAM_AW-1:0];
        next_exp = '0;
        if (rd) begin
            case (kind)
                TGT_RAM:  next_exp = model_ram[ram_idx];
                TGT_ROM:  next_exp = rom_image[sel[ROM_AW-1:0]];
                TGT_UART: next_exp = sel[0] ? DATA_W'(busy_cnt == 0) : DATA_W'(last_byte);
                default:  next_exp = '0;
            endcase
        end
        if (wr && kind == TGT_RAM) begin
            for (int b = 0; b < BE_W; b++) begin
                if (be[b]) model_ram[ram_idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        if (wr && kind == TGT_UART && !sel[0] && busy_cnt == 0) begin
            busy_cnt  = FRAME_CYC;          // Frame starts at the next edge
            last_byte = data[7:0];
            exp_bytes.push_back(data[7:0]);
        end else if (busy_cnt > 0) begin
            busy_cnt--;
        end
        exp_rd = next_exp;
        @(posedge clk);
        #STIM_DELAY;
    endtask

    task automatic idle_cycle();
        bus_access(TGT_NONE, '0, 1'b0, 1'b0, '0, '0);
    endtask

    // ****************************************
    // Test phases
    // ****************************************
    task automatic rom_sweep();
        for (int i = 0; i < ROM_DEPTH; i++) bus_access(TGT_ROM, i, 1'b1, 1'b0, '0, '0);
        for (int i = 0; i < 4; i++) bus_access(TGT_ROM, i * 5, 1'b0, 1'b1, 4'hf, next_rand());
        for (int i = 0; i < ROM_DEPTH; i++) bus_access(TGT_ROM, i, 1'b1, 1'b0, '0, '0);
    endtask

    task automatic ram_fill_and_readback();
        logic [31:0] r;
        for (int i = 0; i < RAM_DEPTH; i++) bus_access(TGT_RAM, i, 1'b0, 1'b1, 4'hf, next_rand());
        for (int i = 0; i < N_RAM_MIX; i++) begin
            r = next_rand();
            bus_access(TGT_RAM, r, 1'b0, 1'b1, r[11:8], next_rand());
        end
        // Back-to-back reads over the whole array
        for (int i = 0; i < RAM_DEPTH; i++) bus_access(TGT_RAM, i, 1'b1, 1'b0, '0, '0);
    endtask

    task automatic uart_frame_sequence();
        for (int n = 0; n < N_UART; n++) begin
            bus_access(TGT_UART, 0, 1'b0, 1'b1, 4'hf, next_rand());
            bus_access(TGT_UART, 0, 1'b0, 1'b1, 4'hf, next_rand());   // Dropped while busy
            bus_access(TGT_UART, 0, 1'b1, 1'b0, '0, '0);
            while (busy_cnt != 0) bus_access(TGT_UART, 1, 1'b1, 1'b0, '0, '0);
            bus_access(TGT_UART, 1, 1'b1, 1'b0, '0, '0);
        end
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        tgt_e        kind;
        for (int i = 0; i < N_RANDOM; i++) begin
            r = next_rand();
            case (r[2:0])
                3'd0, 3'd1, 3'd2: kind = TGT_RAM;
                3'd3:             kind = TGT_ROM;
                3'd4:             kind = TGT_UART;
                default:          kind = TGT_NONE;
            endcase
            if (r[2:0] == 3'd7) begin
                idle_cycle();
            end else begin
                bus_access(kind, next_rand(), r[4:3] != 2'b00, r[4:3] == 2'b00, r[8:5],
                           next_rand());
            end
        end
    endtask

    // Serial receiver sampling near the middle of each bit
    task automatic receive_frame();
        logic [7:0] rx_byte;
        logic [7:0] want;
        @(negedge txd);
        repeat (BAUD_DIV / 2) @(posedge clk);
        #20;
        if (txd !== 1'b0) report_error("UART start bit did not stay low to mid-bit");
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(posedge clk);
            #20;
            rx_byte[i] = txd;
        end
        repeat (BAUD_DIV) @(posedge clk);
        #20;
        if (txd !== 1'b1) report_error("UART stop bit was low");
        if (exp_bytes.size() == 0) report_error("UART sent a frame that no accepted write started");
        want = exp_bytes.pop_front();
        check_byte("txd_o byte", want, rx_byte);
    endtask

    initial begin
        wait (rst_n === 1'b1);
        forever receive_frame();
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_error($sformatf("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        rst_n             = 1'b0;
        master_address    = '0;
        master_byteenable = '0;
        master_read       = 1'b0;
        master_write      = 1'b0;
        master_wrdata     = '0;
        exp_rd            = '0;
        last_byte         = '0;
        busy_cnt          = 0;
        cycle_cnt         = 0;
        rng_state         = 32'ha70c;
        $readmemh("design/boot_rom.hex", rom_image);
        repeat (10) @(posedge clk);
        #STIM_DELAY;
        rst_n = 1'b1;
        check_bit("txd_o", 1'b1, txd);
        check_word("master_rddata_o", '0, master_rddata);
        bus_access(TGT_UART, 1, 1'b1, 1'b0, '0, '0);   // Status reads ready
        rom_sweep();
        ram_fill_and_readback();
        uart_frame_sequence();
        random_traffic();
        while (busy_cnt != 0) idle_cycle();
        repeat (2 * BAUD_DIV) idle_cycle();
        if (exp_bytes.size() != 0) begin
            report_error("UART frames missing for accepted data writes");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: design/boot_rom.hex
// Boot ROM image: one 32-bit word per line, word 0 first
3c1dbfc0
27bd0400
3c088000
25080000
240900ff
ad090000
8d0a0000
3c0bbfd0
356b03f8
240c0041
a16c0000
1000ffff
00000000
deadbeef
0badc0de
5a5aa5a5

// File: compile.f
design/soc_pkg.sv
design/dbus_decode.sv
design/bus_ram.sv
design/boot_rom.sv
design/uart_tx_regs.sv
design/dbus_result.sv
design/soc_bus_top.sv
tests/tb_soc_bus_top.sv

// File: Bender.yml
package:
  name: soc_bus

dependencies: {}

sources:
  # Package first, then leaf modules, then the top level
  - design/soc_pkg.sv
  - design/dbus_decode.sv
  - design/bus_ram.sv
  - design/boot_rom.sv
  - design/uart_tx_regs.sv
  - design/dbus_result.sv
  - design/soc_bus_top.sv

  - target: test
    files:
      - tests/tb_soc_bus_top.sv

# Simulation top: tb_soc_bus_top
# Synthesis top: soc_bus_top
# The boot image design/boot_rom.hex is read at elaboration
# from the project root
# File list for simulators: compile.f
